/* traffic_switch.f */
flow_pkg.sv
word_fifo.sv
class_scheduler.sv
traffic_switch.sv
tb_checker.sv
tb_traffic_switch.sv

/* Bender.yml */
package:
  name: traffic_switch

sources:
  - flow_pkg.sv
  - word_fifo.sv
  - class_scheduler.sv
  - traffic_switch.sv
  - target: test
    files:
      - tb_checker.sv
      - tb_traffic_switch.sv

/* tb_traffic_switch.sv */
`default_nettype none

module tb_traffic_switch;
    timeunit 1ns;
    timeprecision 100ps;

    import flow_pkg::*;

    // Roughly 260 words at a few cycles each under credit stalls, with margin
    localparam int MAX_CYCLES = 4000;

    logic                  clk;
    logic                  reset;
    logic [NUM_PORTS-1:0]  in_push;
    flit_t                 in_flit [NUM_PORTS];
    logic [NUM_PORTS-1:0]  in_full;
    logic [NUM_PORTS-1:0]  out_pop;
    flit_t                 out_flit [NUM_PORTS];
    logic [NUM_PORTS-1:0]  out_empty;

    logic [NUM_PORTS-1:0]  stall;            // Consumer holds these destinations
    flit_t                 send_q [NUM_PORTS][$];
    logic [DATA_W-3:0]     seq [NUM_PORTS];  // Per-class count in the low data bits
    int                    seed = 10;
    int                    cycles = 0;

    traffic_switch UUT (
        .clk       (clk),
        .reset     (reset),
        .in_push   (in_push),
        .in_flit   (in_flit),
        .in_full   (in_full),
        .out_pop   (out_pop),
        .out_flit  (out_flit),
        .out_empty (out_empty)
    );

    tb_checker chk (
        .clk       (clk),
        .reset     (reset),
        .in_push   (in_push),
        .in_flit   (in_flit),
        .in_full   (in_full),
        .out_pop   (out_pop),
        .out_flit  (out_flit),
        .out_empty (out_empty)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #2 clk = ~clk;
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout: traffic still in flight after %0d cycles", MAX_CYCLES);
            $display("Something failed");
            $finish;
        end
    end

    // Every other cycle at most, so a push never lands on a full queue
    always @(posedge clk) begin
        for (int c = 0; c < NUM_PORTS; c++) begin
            if (reset && send_q[c].size() != 0 && !in_full[c] && !in_push[c]) begin
                in_push[c] <= 1'b1;
                in_flit[c] <= send_q[c].pop_front();
            end else begin
                in_push[c] <= 1'b0;
            end
        end
    end

    always @(posedge clk) begin
        for (int d = 0; d < NUM_PORTS; d++) begin
            out_pop[d] <= reset && !stall[d] && !out_empty[d] && !out_pop[d];
        end
    end

    // Class number in the top data bits
    task automatic queue_word(input int cls, input int dest);
        flit_t f;
        f.dest = DEST_W'(dest);
        f.data = {2'(cls), seq[cls]};
        seq[cls] = seq[cls] + 1'b1;
        send_q[cls].push_back(f);
    endtask

    task automatic queue_random(input int count);
        int cls;
        int dest;
        for (int i = 0; i < count; i++) begin
            cls  = {$random(seed)} % NUM_PORTS;
            dest = {$random(seed)} % NUM_PORTS;
            queue_word(cls, dest);
        end
    endtask

    task automatic wait_idle();
        int queued;
        do begin
            @(negedge clk);
            queued = 0;
            for (int c = 0; c < NUM_PORTS; c++) begin
                queued += send_q[c].size();
            end
        end while (queued != 0 || in_push != '0 || chk.pending != 0);
    endtask

    // Longer than the few grants a stalled destination can still absorb
    task automatic wait_stuck();
        int   quiet;
        logic moving;
        quiet = 0;
        while (quiet < 8) begin
            @(negedge clk);
            moving = (in_push != '0) || ((out_empty | stall) != '1);
            for (int c = 0; c < NUM_PORTS; c++) begin
                if (send_q[c].size() != 0 && !in_full[c]) begin
                    moving = 1'b1;
                end
            end
            quiet = moving ? 0 : quiet + 1;
        end
    endtask

    initial begin
        reset   = 1'b0;
        in_push = '0;
        out_pop = '0;
        stall   = '0;
        for (int c = 0; c < NUM_PORTS; c++) begin
            in_flit[c] = '0;
            seq[c]     = '0;
        end
        repeat (5) @(posedge clk);
        reset <= 1'b1;
        @(negedge clk);
        chk.check_reset_state();
        chk.finish_test("reset");

        // Fillers use up the dest 0 credits so every class queue fills first
        stall[0] = 1'b1;
        repeat (OUT_DEPTH) queue_word(3, 0);
        while (send_q[3].size() != 0 || in_push != '0) @(negedge clk);
        for (int k = 0; k < 8; k++) begin
            for (int c = 0; c < NUM_PORTS; c++) begin
                queue_word(c, 0);
            end
        end
        while (in_full != '1) @(negedge clk);
        chk.clear_log();
        stall[0] = 1'b0;
        wait_idle();
        chk.check_weight_order(OUT_DEPTH);
        chk.finish_test("weights");

        queue_random(100);
        wait_idle();
        chk.finish_test("routing");

        queue_random(60);
        wait_idle();
        chk.finish_test("order");

        chk.snapshot_arrivals();
        stall[2] = 1'b1;
        queue_random(60);
        wait_stuck();
        chk.check_progress(2);
        stall[2] = 1'b0;
        wait_idle();
        chk.finish_test("backpressure");

        $display("Tests run %0d, failed %0d, mismatches %0d",
                 chk.tests_run, chk.tests_failed, chk.errors);
        if (chk.tests_failed == 0 && chk.errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* tb_checker.sv */
`default_nettype none

module tb_checker (
    input logic                           clk,
    input logic                           reset,
    input logic [flow_pkg::NUM_PORTS-1:0] in_push,
    input flow_pkg::flit_t                in_flit [flow_pkg::NUM_PORTS],
    input logic [flow_pkg::NUM_PORTS-1:0] in_full,
    input logic [flow_pkg::NUM_PORTS-1:0] out_pop,
    input flow_pkg::flit_t                out_flit [flow_pkg::NUM_PORTS],
    input logic [flow_pkg::NUM_PORTS-1:0] out_empty
);
    timeunit 1ns;
    timeprecision 100ps;

    import flow_pkg::*;

    flit_t expect_q [NUM_PORTS][NUM_PORTS][$];  // By class, then destination
    int    class_log [$];                       // Source classes seen at destination 0
    int    arrivals [NUM_PORTS];
    int    base [NUM_PORTS];
    int    pending = 0;
    int    errors = 0;
    int    test_base = 0;
    int    tests_run = 0;
    int    tests_failed = 0;

    // A word leaves at the destination named by its dest field
    function automatic int expected_dest(input flit_t f);
        return int'(f.dest);
    endfunction

    function automatic int class_of(input flit_t f);
        return int'(f.data[DATA_W-1 -: 2]);
    endfunction

    always @(posedge clk) begin : monitor
        flit_t f;
        int    cls;
        if (reset) begin
            for (int c = 0; c < NUM_PORTS; c++) begin
                if (in_push[c] && !in_full[c]) begin
                    expect_q[c][expected_dest(in_flit[c])].push_back(in_flit[c]);
                    pending++;
                end
            end
            for (int d = 0; d < NUM_PORTS; d++) begin
                if (out_pop[d] && !out_empty[d]) begin
                    f   = out_flit[d];
                    cls = class_of(f);
                    arrivals[d]++;
                    if (d == 0) begin
                        class_log.push_back(cls);
                    end
                    if (expected_dest(f) != d) begin
                        $display("mismatch at %0t: word %h left at destination %0d",
                                 $time, f, d);
                        errors++;
                    end else if (expect_q[cls][d].size() == 0) begin
                        $display("mismatch at %0t: unexpected word %h at destination %0d",
                                 $time, f, d);
                        errors++;
                    end else begin
                        if (f !== expect_q[cls][d][0]) begin
                            $display("mismatch at %0t: destination %0d got %h, expected %h",
                                     $time, d, f, expect_q[cls][d][0]);
                            errors++;
                        end
                        void'(expect_q[cls][d].pop_front());
                        pending--;
                    end
                end
            end
        end
    end

    task automatic check_reset_state();
        if (out_empty !== '1 || in_full !== '0) begin
            $display("mismatch at %0t: flags after reset out_empty %b, in_full %b",
                     $time, out_empty, in_full);
            errors++;
        end
    endtask

    task automatic clear_log();
        class_log.delete();
    endtask

    // Grant order for weights 4, 3, 2, 1, skipping words already waiting
    task automatic check_weight_order(input int skip);
        int expected [10] = '{0, 0, 0, 0, 1, 1, 1, 2, 2, 3};
        if (class_log.size() < skip + $size(expected)) begin
            $display("Only %0d words reached destination 0 in the weight test", class_log.size());
            errors++;
        end else begin
            for (int i = 0; i < $size(expected); i++) begin
                if (class_log[skip + i] != expected[i]) begin
                    $display("mismatch at %0t: arrival %0d came from class %0d, expected %0d",
                             $time, i, class_log[skip + i], expected[i]);
                    errors++;
                end
            end
        end
    endtask

    task automatic snapshot_arrivals();
        base = arrivals;
    endtask

    task automatic check_progress(input int stalled);
        for (int d = 0; d < NUM_PORTS; d++) begin
            if (d != stalled && arrivals[d] == base[d]) begin
                $display("Destination %0d delivered nothing while destination %0d was stalled",
                         d, stalled);
                errors++;
            end
        end
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        if (errors == test_base) begin
            $display("Test %s passed", name);
        end else begin
            tests_failed++;
            $display("Test %s failed with %0d errors", name, errors - test_base);
        end
        test_base = errors;
    endtask

endmodule

`default_nettype wire

/* traffic_switch.sv */
`default_nettype none

module traffic_switch (
    input  logic                           clk,
    input  logic                           reset,
    input  logic [flow_pkg::NUM_PORTS-1:0] in_push,
    input  flow_pkg::flit_t                in_flit [flow_pkg::NUM_PORTS],
    output logic [flow_pkg::NUM_PORTS-1:0] in_full,
    input  logic [flow_pkg::NUM_PORTS-1:0] out_pop,
    output flow_pkg::flit_t                out_flit [flow_pkg::NUM_PORTS],
    output logic [flow_pkg::NUM_PORTS-1:0] out_empty
);
    import flow_pkg::*;

    flit_t                head_flit [NUM_PORTS];
    logic [NUM_PORTS-1:0] head_empty;
    logic [NUM_PORTS-1:0] class_pop;
    flit_t                route_flit;
    logic [NUM_PORTS-1:0] route_push;

    // One queue per traffic class
    for (genvar c = 0; c < NUM_PORTS; c++) begin : g_class_q
        word_fifo #(
            .DEPTH(IN_DEPTH)
        ) u_class_q (
            .clk     (clk),
            .reset   (reset),
            .push    (in_push[c]),
            .wr_flit (in_flit[c]),
            .pop     (class_pop[c]),
            .rd_flit (head_flit[c]),
            .empty   (head_empty[c]),
            .full    (in_full[c])
        );
    end

    class_scheduler u_sched (
        .clk           (clk),
        .reset         (reset),
        .head_flit     (head_flit),
        .head_empty    (head_empty),
        .class_pop     (class_pop),
        .credit_return (out_pop),  // Each consumer pop frees one slot
        .route_flit    (route_flit),
        .route_push    (route_push)
    );

    // One queue per destination, drained outside
    for (genvar d = 0; d < NUM_PORTS; d++) begin : g_dest_q
        word_fifo #(
            .DEPTH(OUT_DEPTH)
        ) u_dest_q (
            .clk     (clk),
            .reset   (reset),
            .push    (route_push[d]),
            .wr_flit (route_flit),
            .pop     (out_pop[d]),
            .rd_flit (out_flit[d]),
            .empty   (out_empty[d]),
            .full    ()  // Credits keep pushes off a full queue
        );
    end

endmodule

`default_nettype wire

/* class_scheduler.sv */
`default_nettype none

module class_scheduler (
    input  logic                           clk,
    input  logic                           reset,
    input  flow_pkg::flit_t                head_flit [flow_pkg::NUM_PORTS],
    input  logic [flow_pkg::NUM_PORTS-1:0] head_empty,
    output logic [flow_pkg::NUM_PORTS-1:0] class_pop,
    input  logic [flow_pkg::NUM_PORTS-1:0] credit_return,
    output flow_pkg::flit_t                route_flit,
    output logic [flow_pkg::NUM_PORTS-1:0] route_push
);
    import flow_pkg::*;

    traffic_class_e       cur_class;
    traffic_class_e       grant_class;
    logic [WEIGHT_W-1:0]  weight_left;  // Grants left for cur_class
    logic [WEIGHT_W-1:0]  weight_next;
    logic [CREDIT_W-1:0]  credit [NUM_PORTS];
    logic [NUM_PORTS-1:0] eligible;
    logic [NUM_PORTS-1:0] spend;
    logic                 grant_valid;
    flit_t                grant_flit;

    // Head present and its destination has room
    always_comb begin
        for (int c = 0; c < NUM_PORTS; c++) begin
            eligible[c] = !head_empty[c] && (credit[head_flit[c].dest] != '0);
        end
    end

    always_comb begin : pick
        traffic_class_e cand;
        cand        = cur_class;
        grant_valid = 1'b0;
        grant_class = cur_class;
        weight_next = weight_left;
        if (eligible[cur_class] && (weight_left != '0)) begin
            grant_valid = 1'b1;
            weight_next = weight_left - 1'b1;
        end else begin
            // Offset NUM_PORTS comes back to cur_class with a fresh weight
            for (int i = 1; i <= NUM_PORTS; i++) begin
                cand = traffic_class_e'(2'(cur_class + i));
                if (!grant_valid && eligible[cand]) begin
                    grant_valid = 1'b1;
                    grant_class = cand;
                    weight_next = CLASS_WEIGHT[cand] - 1'b1;  // First grant spent now
                end
            end
        end
    end

    assign grant_flit = head_flit[grant_class];

    always_comb begin
        class_pop = '0;
        spend     = '0;
        if (grant_valid) begin
            class_pop[grant_class]  = 1'b1;
            spend[grant_flit.dest]  = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!reset) begin
            cur_class   <= CLASS_0;
            weight_left <= CLASS_WEIGHT[CLASS_0];
            route_push  <= '0;
            for (int d = 0; d < NUM_PORTS; d++) begin
                credit[d] <= CREDIT_W'(OUT_DEPTH);
            end
        end else begin
            if (grant_valid) begin
                cur_class   <= grant_class;
                weight_left <= weight_next;
            end
            route_push <= spend;  // One-hot on the word's destination
            for (int d = 0; d < NUM_PORTS; d++) begin
                credit[d] <= credit[d] - CREDIT_W'(spend[d]) + CREDIT_W'(credit_return[d]);
            end
        end
    end

    always_ff @(posedge clk) begin
        route_flit <= grant_flit;
    end

    assert property (@(posedge clk) disable iff (!reset) $onehot0(class_pop))
        else $error("class_scheduler: more than one class popped");

    for (genvar d = 0; d < NUM_PORTS; d++) begin : g_credit_chk
        // A pop without a matching push would overflow the counter
        assert property (@(posedge clk) disable iff (!reset)
            credit[d] <= CREDIT_W'(OUT_DEPTH))
            else $error("class_scheduler: credit overflow on destination %0d", d);

        assert property (@(posedge clk) disable iff (!reset)
            route_push[d] |-> $past(credit[d] != '0))
            else $error("class_scheduler: push to destination %0d without credit", d);
    end

endmodule

`default_nettype wire

/* word_fifo.sv */
`default_nettype none

module word_fifo #(
    parameter int DEPTH = 4
) (
    input  logic            clk,
    input  logic            reset,
    input  logic            push,
    input  flow_pkg::flit_t wr_flit,
    input  logic            pop,
    output flow_pkg::flit_t rd_flit,
    output logic            empty,
    output logic            full
);
    import flow_pkg::*;

    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);

    flit_t            mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             do_push;
    logic             do_pop;

    // Wrap for depths that are not a power of two
    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign do_push = push && !full;  // Push on full is dropped
    assign do_pop  = pop && !empty;
    assign empty   = (count == '0);
    assign full    = (count == CNT_W'(DEPTH));
    assign rd_flit = mem[rd_ptr];    // Head always visible

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= wr_flit;
        end
    end

    always_ff @(posedge clk) begin
        if (!reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (do_pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Producer and consumer must respect the flags
    assert property (@(posedge clk) disable iff (!reset) push |-> !full)
        else $error("word_fifo: push while full");

    assert property (@(posedge clk) disable iff (!reset) pop |-> !empty)
        else $error("word_fifo: pop while empty");

endmodule

`default_nettype wire

/* flow_pkg.sv */
`default_nettype none

package flow_pkg;

    localparam int NUM_PORTS = 4;  // Classes and destinations
    localparam int DEST_W    = 2;
    localparam int DATA_W    = 8;

    localparam int IN_DEPTH  = 4;
    localparam int OUT_DEPTH = 4;  // Also the credit count after reset

    localparam int CREDIT_W  = $clog2(OUT_DEPTH + 1);
    localparam int WEIGHT_W  = 3;

    // Grants per turn, class 0 first
    localparam logic [WEIGHT_W-1:0] CLASS_WEIGHT [NUM_PORTS] = '{
        3'd4,
        3'd3,
        3'd2,
        3'd1
    };

    typedef struct packed {
        logic [DEST_W-1:0] dest;
        logic [DATA_W-1:0] data;
    } flit_t;

    typedef enum logic [1:0] {
        CLASS_0,
        CLASS_1,
        CLASS_2,
        CLASS_3
    } traffic_class_e;

endpackage

`default_nettype wire
